// ==== list.f ====
+incdir+rtl
rtl/chacha_pkg.sv
rtl/chacha_quarter_round.sv
rtl/chacha_half_round.sv
rtl/chacha_round_ctrl.sv
rtl/chacha_state_regs.sv
rtl/chacha_block.sv
tests/tb_clock_gen.sv
tests/tb_chacha_checker.sv
tests/chacha_block_assert.sv
tests/tb_chacha_block.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_chacha_block
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG) || (echo "test failed" && exit 1)
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_chacha_block.sv ====
`timescale 1ns/1ns

module tb_chacha_block;
    import chacha_pkg::*;

    localparam int NUM_ROWS       = 11;
    localparam int BUSY_ROW       = 4;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 25 + 8 + 50;
    localparam logic [31:0] SEED  = 32'hc694_dd74;

    // RFC 8439 section 2.3.2 block output, words 0 to 15
    localparam logic [31:0] KAT_WORDS [16] = '{
        32'he4e7f110, 32'h15593bd1, 32'h1fdd0f50, 32'hc47120a3,
        32'hc7f4d1c7, 32'h0368c033, 32'h9aaa2204, 32'h4e6cd4c3,
        32'h466482d2, 32'h09aa9f07, 32'h05d7c214, 32'ha2028bd9,
        32'hd19c12b5, 32'hb94e16de, 32'he883d0cb, 32'h4e3c50a2
    };

    // One row of the stimulus table
    typedef struct packed {
        block_input_t blk;
        logic         has_ref;
        keystream_t   ref_ks;
        logic         busy_start;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         start;
    block_input_t blk_in;
    keystream_t   keystream;
    logic         done;
    logic         row_has_ref;
    keystream_t   row_ref;

    row_t         rows [NUM_ROWS];
    int           cycle_cnt = 0;
    int           total_errs;

    tb_clock_gen clk_gen_i (
        .clk  (clk),
        .rst_n(rst_n)
    );

    chacha_block dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .blk_in   (blk_in),
        .keystream(keystream),
        .done     (done)
    );

    tb_chacha_checker chk_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .blk_in   (blk_in),
        .keystream(keystream),
        .done     (done),
        .ref_valid(row_has_ref),
        .ref_ks   (row_ref)
    );

    // ====================
    // Stimulus table
    // ====================
    task automatic build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i] = '0;
        end
        // Row 0 is the published vector, key bytes 00..1f
        for (int k = 0; k < 8; k++) begin
            rows[0].blk.key[k] = {8'(4 * k + 3), 8'(4 * k + 2), 8'(4 * k + 1), 8'(4 * k)};
        end
        rows[0].blk.counter  = 32'h0000_0001;
        rows[0].blk.nonce[0] = 32'h0900_0000;
        rows[0].blk.nonce[1] = 32'h4a00_0000;
        rows[0].blk.nonce[2] = 32'h0000_0000;
        rows[0].has_ref      = 1'b1;
        for (int w = 0; w < 16; w++) begin
            rows[0].ref_ks[w] = KAT_WORDS[w];
        end
        // Row 1 stays all zero, row 2 is all ones
        rows[2].blk = '1;
        // Rows 3 to 10 are random
        for (int i = 3; i < NUM_ROWS; i++) begin
            for (int k = 0; k < 8; k++) begin
                rows[i].blk.key[k] = $urandom();
            end
            rows[i].blk.counter = $urandom();
            for (int n = 0; n < 3; n++) begin
                rows[i].blk.nonce[n] = $urandom();
            end
        end
        rows[BUSY_ROW].busy_start = 1'b1;
    endtask

    task automatic run_row(input int idx);
        @(posedge clk);
        blk_in      <= rows[idx].blk;
        row_has_ref <= rows[idx].has_ref;
        row_ref     <= rows[idx].ref_ks;
        start       <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // Second start in the middle of the rounds, other inputs
        if (rows[idx].busy_start) begin
            repeat (5) @(posedge clk);
            blk_in <= ~rows[idx].blk;
            start  <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        start       <= 1'b0;
        blk_in      <= '0;
        row_has_ref <= 1'b0;
        row_ref     <= '0;
        void'($urandom(SEED));
        build_table();
        @(posedge rst_n);
        @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        // Let the checker see the end of the last done pulse
        repeat (4) @(posedge clk);
        total_errs = chk_i.err_count + dut_i.u_ctrl.u_assert.fail_count;
        if (chk_i.rows_seen != NUM_ROWS) begin
            $display("only %0d of %0d rows produced a result", chk_i.rows_seen, NUM_ROWS);
            total_errs++;
        end
        $display("rows %0d, rows failed %0d, errors %0d",
                 chk_i.rows_seen, chk_i.rows_failed, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// ==== tests/chacha_block_assert.sv ====
`timescale 1ns/1ns

module chacha_block_assert (
    input logic clk,
    input logic rst_n,
    input logic load,
    input logic round_en,
    input logic finish,
    input logic done
);
    // Cycles from a load until the controller is back in idle
    localparam int BUSY_CYCLES = 21;

    // Length of the current run of round cycles
    int run_len;
    // Cycles left before another load may happen
    int busy_left;
    // Number of failed assertions
    int fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= 0;
        end else if (round_en) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_left <= 0;
        end else if (load) begin
            busy_left <= BUSY_CYCLES;
        end else if (busy_left > 0) begin
            busy_left <= busy_left - 1;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    a_load_idle: assert property (@(posedge clk) disable iff (!rst_n) load |-> busy_left == 0)
        else begin
            fail_count++;
            $error("load raised while a block is still in flight");
        end

    a_round_limit: assert property (@(posedge clk) disable iff (!rst_n) round_en |-> run_len < 20)
        else begin
            fail_count++;
            $error("more than 20 round cycles in a row");
        end

    a_finish_count: assert property (@(posedge clk) disable iff (!rst_n) finish |-> run_len == 20)
        else begin
            fail_count++;
            $error("finish not preceded by exactly 20 round cycles");
        end

endmodule

bind chacha_round_ctrl chacha_block_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .round_en(round_en),
    .finish  (finish),
    .done    (done)
);

// ==== tests/tb_chacha_checker.sv ====
`timescale 1ns/1ns

module tb_chacha_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input chacha_pkg::block_input_t blk_in,
    input chacha_pkg::keystream_t   keystream,
    input logic                     done,
    input logic                     ref_valid,
    input chacha_pkg::keystream_t   ref_ks
);
    import chacha_pkg::*;

    // done is registered at the 21st edge after start and seen one edge later
    localparam int DONE_EDGE = 22;

    int         err_count   = 0;
    int         rows_seen   = 0;
    int         rows_failed = 0;
    logic       busy        = 1'b0;
    logic       reset_seen  = 1'b0;
    int         edge_cnt    = 0;
    keystream_t exp_ks;
    keystream_t exp_ref;
    logic       exp_has_ref;
    keystream_t held_ks     = '0;

    // ====================
    // Reference model
    // ====================
    function automatic logic [31:0] rotate_left(input logic [31:0] v, input int n);
        return (v << n) | (v >> (32 - n));
    endfunction

    function automatic keystream_t model_block(input block_input_t b);
        logic [31:0] init [16];
        logic [31:0] x [16];
        keystream_t  result;
        int          ia;
        int          ib;
        int          ic;
        int          id;
        // "expand 32-byte k"
        init[0] = 32'h6170_7865;
        init[1] = 32'h3320_646e;
        init[2] = 32'h7962_2d32;
        init[3] = 32'h6b20_6574;
        for (int i = 0; i < 8; i++) begin
            init[4 + i] = b.key[i];
        end
        init[12] = b.counter;
        for (int i = 0; i < 3; i++) begin
            init[13 + i] = b.nonce[i];
        end
        x = init;
        for (int r = 0; r < 20; r++) begin
            for (int q = 0; q < 4; q++) begin
                ia = q;
                if (r % 2 == 0) begin
                    ib = 4 + q;
                    ic = 8 + q;
                    id = 12 + q;
                end else begin
                    ib = 4 + (q + 1) % 4;
                    ic = 8 + (q + 2) % 4;
                    id = 12 + (q + 3) % 4;
                end
                x[ia] = x[ia] + x[ib];
                x[id] = rotate_left(x[id] ^ x[ia], 16);
                x[ic] = x[ic] + x[id];
                x[ib] = rotate_left(x[ib] ^ x[ic], 12);
                x[ia] = x[ia] + x[ib];
                x[id] = rotate_left(x[id] ^ x[ia], 8);
                x[ic] = x[ic] + x[id];
                x[ib] = rotate_left(x[ib] ^ x[ic], 7);
            end
        end
        for (int i = 0; i < 16; i++) begin
            result[i] = x[i] + init[i];
        end
        return result;
    endfunction

    // Compare one finished block
    task automatic close_row();
        int row_errs;
        row_errs = 0;
        if (done !== 1'b1) begin
            $display("row %0d: done did not rise 21 cycles after start", rows_seen);
            row_errs++;
        end
        for (int i = 0; i < 16; i++) begin
            if (keystream[i] !== exp_ks[i]) begin
                $display("FAIL keystream[%0d] row %0d: expected %08h, got %08h",
                         i, rows_seen, exp_ks[i], keystream[i]);
                row_errs++;
            end
            if (exp_has_ref && keystream[i] !== exp_ref[i]) begin
                $display("FAIL keystream[%0d] row %0d: vector %08h, got %08h",
                         i, rows_seen, exp_ref[i], keystream[i]);
                row_errs++;
            end
        end
        held_ks   = keystream;
        err_count = err_count + row_errs;
        if (row_errs == 0) begin
            $display("row %0d passed", rows_seen);
        end else begin
            $display("row %0d failed with %0d errors", rows_seen, row_errs);
            rows_failed++;
        end
        rows_seen++;
        busy = 1'b0;
    endtask

    // ====================
    // Monitor
    // ====================
    always @(posedge clk) begin
        if (!rst_n) begin
            // The first edge only applies the reset
            if (reset_seen) begin
                if (done !== 1'b0) begin
                    $display("FAIL done in reset: expected %h, got %h", 1'b0, done);
                    err_count++;
                end
                if (keystream !== '0) begin
                    $display("FAIL keystream in reset: expected %h, got %h",
                             512'h0, keystream);
                    err_count++;
                end
            end
            reset_seen = 1'b1;
            busy       = 1'b0;
        end else begin
            if (busy) begin
                edge_cnt = edge_cnt + 1;
                if (edge_cnt == DONE_EDGE) begin
                    close_row();
                end else if (done === 1'b1) begin
                    $display("row %0d: done came %0d cycles after start instead of 21",
                             rows_seen, edge_cnt - 1);
                    err_count++;
                end
            end else if (done === 1'b1) begin
                $display("done high with no block in flight or for more than one cycle");
                err_count++;
            end

            // keystream only moves together with done
            if (done !== 1'b1 && keystream !== held_ks) begin
                $display("FAIL keystream changed between done pulses: held %h, got %h",
                         held_ks, keystream);
                err_count++;
                held_ks = keystream;
            end

            if (!busy && start === 1'b1) begin
                exp_ks      = model_block(blk_in);
                exp_has_ref = ref_valid;
                exp_ref     = ref_ks;
                edge_cnt    = 0;
                busy        = 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset released on a rising edge after RESET_CYCLES cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== rtl/chacha_block.sv ====
`timescale 1ns/1ns

module chacha_block (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  chacha_pkg::block_input_t blk_in,
    output chacha_pkg::keystream_t   keystream,
    output logic                     done
);
    import chacha_pkg::*;

    logic          load;
    logic          round_en;
    logic          diagonal;
    logic          finish;
    chacha_state_u working;
    chacha_state_u next_state;

    chacha_round_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .load    (load),
        .round_en(round_en),
        .diagonal(diagonal),
        .finish  (finish),
        .done    (done)
    );

    chacha_state_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .round_en  (round_en),
        .finish    (finish),
        .blk_in    (blk_in),
        .next_state(next_state),
        .working   (working),
        .keystream (keystream)
    );

    // One column or diagonal round per cycle
    chacha_half_round u_half (
        .working   (working),
        .diagonal  (diagonal),
        .next_state(next_state)
    );

endmodule

// ==== rtl/chacha_state_regs.sv ====
`timescale 1ns/1ns
`include "chacha_defines.svh"

module chacha_state_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic                      round_en,
    input  logic                      finish,
    input  chacha_pkg::block_input_t  blk_in,
    input  chacha_pkg::chacha_state_u next_state,
    output chacha_pkg::chacha_state_u working,
    output chacha_pkg::keystream_t    keystream
);
    import chacha_pkg::*;

    chacha_state_u init_state;
    chacha_state_u load_state;
    keystream_t    sum_words;

    // ====================
    // Initial state from the input bundle
    // ====================
    always_comb begin
        load_state.fields.sigma[0] = `CHACHA_CONST_0;
        load_state.fields.sigma[1] = `CHACHA_CONST_1;
        load_state.fields.sigma[2] = `CHACHA_CONST_2;
        load_state.fields.sigma[3] = `CHACHA_CONST_3;
        load_state.fields.key      = blk_in.key;
        load_state.fields.counter  = blk_in.counter;
        load_state.fields.nonce    = blk_in.nonce;
    end

    // Feed-forward, word by word modulo 2^32
    always_comb begin
        for (int i = 0; i < `CHACHA_WORDS; i++) begin
            sum_words[i] = init_state.words[i] + working.words[i];
        end
    end

    // ====================
    // State registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_state <= '0;
            working    <= '0;
        end else if (load) begin
            init_state <= load_state;
            working    <= load_state;
        end else if (round_en) begin
            working <= next_state;
        end
    end

    // Holds the last block until the next finish
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keystream <= '0;
        end else if (finish) begin
            keystream <= sum_words;
        end
    end

endmodule

// ==== rtl/chacha_round_ctrl.sv ====
`timescale 1ns/1ns
`include "chacha_defines.svh"

module chacha_round_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic load,
    output logic round_en,
    output logic diagonal,
    output logic finish,
    output logic done
);
    localparam int CNT_W = $clog2(`CHACHA_ROUNDS);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ROUNDS = 2'd1;
    localparam logic [1:0] ST_FINISH = 2'd2;

    logic [1:0]       state;
    logic [CNT_W-1:0] round_cnt;

    // ====================
    // Strobes
    // ====================
    assign load     = (state == ST_IDLE) && start;
    assign round_en = (state == ST_ROUNDS);
    assign finish   = (state == ST_FINISH);

    // Even rounds work on columns, odd rounds on diagonals
    assign diagonal = round_cnt[0];

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            round_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= finish;
            case (state)
                ST_IDLE: begin
                    round_cnt <= '0;
                    if (start) begin
                        state <= ST_ROUNDS;
                    end
                end
                ST_ROUNDS: begin
                    round_cnt <= round_cnt + 1'b1;
                    if (round_cnt == CNT_W'(`CHACHA_ROUNDS - 1)) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    // Sum is taken on this edge, back to idle
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/chacha_half_round.sv ====
`timescale 1ns/1ns

module chacha_half_round (
    input  chacha_pkg::chacha_state_u working,
    input  logic                      diagonal,
    output chacha_pkg::chacha_state_u next_state
);
    import chacha_pkg::*;

    // Word indices per quarter round, in a, b, c, d order
    localparam int COL_IDX [4][4] = '{
        '{0, 4,  8, 12},
        '{1, 5,  9, 13},
        '{2, 6, 10, 14},
        '{3, 7, 11, 15}
    };
    localparam int DIAG_IDX [4][4] = '{
        '{0, 5, 10, 15},
        '{1, 6, 11, 12},
        '{2, 7,  8, 13},
        '{3, 4,  9, 14}
    };

    word_t qr_in  [4][4];
    word_t qr_out [4][4];

    // ====================
    // Gather and quarter rounds
    // ====================
    for (genvar q = 0; q < 4; q++) begin : g_qr
        for (genvar k = 0; k < 4; k++) begin : g_sel
            assign qr_in[q][k] = diagonal ? working.words[DIAG_IDX[q][k]]
                                          : working.words[COL_IDX[q][k]];
        end

        chacha_quarter_round u_qr (
            .a    (qr_in[q][0]),
            .b    (qr_in[q][1]),
            .c    (qr_in[q][2]),
            .d    (qr_in[q][3]),
            .a_out(qr_out[q][0]),
            .b_out(qr_out[q][1]),
            .c_out(qr_out[q][2]),
            .d_out(qr_out[q][3])
        );
    end

    // ====================
    // Scatter back to the same positions
    // ====================
    always_comb begin
        next_state = working;
        for (int q = 0; q < 4; q++) begin
            for (int k = 0; k < 4; k++) begin
                if (diagonal) begin
                    next_state.words[DIAG_IDX[q][k]] = qr_out[q][k];
                end else begin
                    next_state.words[COL_IDX[q][k]] = qr_out[q][k];
                end
            end
        end
    end

endmodule

// ==== rtl/chacha_quarter_round.sv ====
`timescale 1ns/1ns
`include "chacha_defines.svh"

module chacha_quarter_round (
    input  chacha_pkg::word_t a,
    input  chacha_pkg::word_t b,
    input  chacha_pkg::word_t c,
    input  chacha_pkg::word_t d,
    output chacha_pkg::word_t a_out,
    output chacha_pkg::word_t b_out,
    output chacha_pkg::word_t c_out,
    output chacha_pkg::word_t d_out
);
    import chacha_pkg::*;

    word_t a1;
    word_t b1;
    word_t c1;
    word_t d1;

    function automatic word_t rotl(input word_t x, input int unsigned n);
        return (x << n) | (x >> (`CHACHA_WORD_W - n));
    endfunction

    // First half, rotations 16 and 12
    assign a1 = a + b;
    assign d1 = rotl(d ^ a1, 16);
    assign c1 = c + d1;
    assign b1 = rotl(b ^ c1, 12);

    // Second half, rotations 8 and 7
    assign a_out = a1 + b1;
    assign d_out = rotl(d1 ^ a_out, 8);
    assign c_out = c1 + d_out;
    assign b_out = rotl(b1 ^ c_out, 7);

endmodule

// ==== rtl/chacha_pkg.sv ====
`include "chacha_defines.svh"

package chacha_pkg;

    typedef logic [`CHACHA_WORD_W-1:0] word_t;

    // Index 0 sits in the low bits, so key[i] feeds state word 4+i
    typedef word_t [7:0] key_t;
    typedef word_t [2:0] nonce_t;

    // Top-level input bundle
    typedef struct packed {
        key_t   key;
        word_t  counter;
        nonce_t nonce;
    } block_input_t;

    // Highest state word first, so word 0 lands in the low bits
    typedef struct packed {
        nonce_t      nonce;
        word_t       counter;
        key_t        key;
        word_t [3:0] sigma;
    } state_fields_t;

    // Named view at load time, indexed view in the rounds
    typedef union packed {
        word_t [`CHACHA_WORDS-1:0] words;
        state_fields_t             fields;
    } chacha_state_u;

    typedef word_t [`CHACHA_WORDS-1:0] keystream_t;

endpackage

// ==== rtl/chacha_defines.svh ====
`ifndef CHACHA_DEFINES_SVH
`define CHACHA_DEFINES_SVH

// ====================
// State geometry
// ====================
`define CHACHA_WORD_W 32
`define CHACHA_WORDS  16
`define CHACHA_ROUNDS 20

// ====================
// Sigma words, "expand 32-byte k" read as little-endian words
// ====================
`define CHACHA_CONST_0 32'h6170_7865
`define CHACHA_CONST_1 32'h3320_646e
`define CHACHA_CONST_2 32'h7962_2d32
`define CHACHA_CONST_3 32'h6b20_6574

`endif
